//--- common/spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

////////////////////////////////////////////////////////////
// I/O bus geometry
////////////////////////////////////////////////////////////

`define SPI_ADDR_W 12

////////////////////////////////////////////////////////////
// Flash channel register map
////////////////////////////////////////////////////////////

`define SPI_REG_PINS    12'h110 // Bit-bang pins, lane read-back
`define SPI_REG_START8  12'h111 // Start 8-bit transfer, rx read-back
`define SPI_REG_START16 12'h112 // Start 16-bit transfer, rx read-back
`define SPI_REG_IDLE    12'h113 // Engine idle in bit 0
`define SPI_REG_DIR     12'h114 // Quad lane direction, 1 = input
`define SPI_REG_QUAD    12'h115 // Quad mode enable

////////////////////////////////////////////////////////////
// Transfer counter start values
////////////////////////////////////////////////////////////

// Counter wraps at 32, so these set the transfer length
`define SPI_CNT_START8  5'd16
`define SPI_CNT_START16 5'd0

`endif

//--- common/io_bus_pkg.sv
`include "spi_settings.svh"

`default_nettype none

package io_bus_pkg;

  ////////////////////////////////////////////////////////////
  // CPU side I/O bus
  ////////////////////////////////////////////////////////////

  typedef logic [`SPI_ADDR_W-1:0] io_addr_t;
  typedef logic [15:0]            io_data_t;

  // One request per clock, strobes last a single cycle
  typedef struct packed {
    logic     wr;    // Write strobe
    logic     rd;    // Read strobe
    io_addr_t addr;
    io_data_t wdata;
  } io_req_t;

endpackage

`default_nettype wire

//--- common/spi_pin_pkg.sv
`default_nettype none

package spi_pin_pkg;

  // 3: IO3, 2: IO2, 1: MISO, 0: MOSI
  typedef logic [3:0] spi_lanes_t;

  // Pin order CS SCK IO3 IO2 MISO MOSI
  typedef struct packed {
    logic       cs;
    logic       sck;
    spi_lanes_t dq;
  } spi_pins_t;

  typedef struct packed {
    logic                 start8;  // Single-cycle strobe
    logic                 start16; // Single-cycle strobe
    io_bus_pkg::io_data_t tx;
    logic                 quad;
    logic                 dir;
  } spi_cmd_t;

  typedef logic [4:0] xfer_cnt_t;

  typedef enum logic {
    XFER_IDLE,
    XFER_RUN
  } xfer_state_t;

endpackage

`default_nettype wire

//--- hw/spi_regs.sv
`include "spi_settings.svh"

`default_nettype none

module spi_regs (
  input  wire logic                    pclk,
  input  wire logic                    SCKclock,
  input  wire io_bus_pkg::io_req_t     req_i,
  input  wire io_bus_pkg::io_data_t    rx_i,
  input  wire logic                    idle_i,
  input  wire spi_pin_pkg::spi_lanes_t lanes_i,
  output spi_pin_pkg::spi_cmd_t        cmd_o,
  output spi_pin_pkg::spi_pins_t       bitbang_o,
  output io_bus_pkg::io_data_t         rd_data_o,
  output logic                         rd_valid_o
);
  import io_bus_pkg::*;
  import spi_pin_pkg::*;

  spi_pins_t bitbang_q;
  logic      dir_q;
  logic      quad_q;
  logic      wr_pins;
  logic      wr_start8;
  logic      wr_start16;
  logic      wr_dir;
  logic      wr_quad;
  io_data_t  rd_mux;
  io_data_t  rd_data_q;
  logic      rd_valid_q;

  function automatic logic wr_hit(input io_req_t req, input io_addr_t addr);
    return req.wr && (req.addr == addr);
  endfunction

  ////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////

  assign wr_pins    = wr_hit(req_i, `SPI_REG_PINS);
  assign wr_start8  = wr_hit(req_i, `SPI_REG_START8);
  assign wr_start16 = wr_hit(req_i, `SPI_REG_START16);
  assign wr_dir     = wr_hit(req_i, `SPI_REG_DIR);
  assign wr_quad    = wr_hit(req_i, `SPI_REG_QUAD);

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      bitbang_q <= '0;
      dir_q     <= 1'b0;
      quad_q    <= 1'b0;
    end else begin
      if (wr_pins)
        bitbang_q <= spi_pins_t'(req_i.wdata[5:0]);
      if (wr_dir)
        dir_q <= req_i.wdata[0];
      if (wr_quad)
        quad_q <= req_i.wdata[0];
    end
  end

  // Start strobes pass straight through with the write data
  assign cmd_o = '{
    start8:  wr_start8,
    start16: wr_start16,
    tx:      req_i.wdata,
    quad:    quad_q,
    dir:     dir_q
  };

  assign bitbang_o = bitbang_q;

  ////////////////////////////////////////////////////////////
  // Read back
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (req_i.addr)
      `SPI_REG_PINS:    rd_mux = {12'd0, lanes_i};
      `SPI_REG_START8,
      `SPI_REG_START16: rd_mux = rx_i;
      `SPI_REG_IDLE:    rd_mux = {15'd0, idle_i};
      default:          rd_mux = '0;
    endcase
  end

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      rd_valid_q <= 1'b0;
    end else begin
      rd_valid_q <= req_i.rd;
    end
  end

  always_ff @(posedge pclk) begin
    if (req_i.rd)
      rd_data_q <= rd_mux; // Held until the next read
  end

  assign rd_data_o  = rd_data_q;
  assign rd_valid_o = rd_valid_q;

endmodule

`default_nettype wire

//--- spi/spi_shift_engine.sv
`include "spi_settings.svh"

`default_nettype none

module spi_shift_engine (
  input  wire logic                    pclk,
  input  wire logic                    SCKclock,
  input  wire spi_pin_pkg::spi_cmd_t   cmd_i,
  input  wire spi_pin_pkg::spi_lanes_t lanes_i,
  output spi_pin_pkg::spi_pins_t       pins_o,
  output spi_pin_pkg::spi_lanes_t      mask_o,
  output io_bus_pkg::io_data_t         rx_o,
  output logic                         idle_o
);
  import io_bus_pkg::*;
  import spi_pin_pkg::*;

  xfer_state_t state_q;
  xfer_cnt_t   cnt_q;
  xfer_cnt_t   cnt_step;
  xfer_cnt_t   cnt_next;
  xfer_cnt_t   cnt_load;
  io_data_t    shift_q;
  io_data_t    shift_next;
  io_data_t    tx_swap;
  spi_lanes_t  dq_out;
  logic        start;
  logic        sck;

  ////////////////////////////////////////////////////////////
  // Counter and clock
  ////////////////////////////////////////////////////////////

  assign start    = cmd_i.start8 | cmd_i.start16;
  assign cnt_load = cmd_i.start8 ? `SPI_CNT_START8 : `SPI_CNT_START16;
  assign cnt_step = cmd_i.quad ? 5'd4 : 5'd1;
  assign cnt_next = cnt_q + cnt_step;

  // Counter sits at zero while idle, which keeps SCK low
  assign sck = cmd_i.quad ? cnt_q[2] : cnt_q[0];

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign tx_swap = {cmd_i.tx[7:0], cmd_i.tx[15:8]}; // Low byte goes out first

  assign shift_next = cmd_i.quad ? {shift_q[11:0], lanes_i}
                                 : {shift_q[14:0], lanes_i[1]}; // MISO only

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      state_q <= XFER_IDLE;
      cnt_q   <= '0;
      shift_q <= '0;
    end else if (start) begin
      // A new command also restarts a running transfer
      state_q <= XFER_RUN;
      cnt_q   <= cnt_load;
      shift_q <= tx_swap;
    end else begin
      case (state_q)
        XFER_RUN: begin
          cnt_q <= cnt_next;
          if (cnt_next == '0)
            state_q <= XFER_IDLE; // Wrap ends the transfer
          if (sck)
            shift_q <= shift_next;
        end
        default: begin
          state_q <= XFER_IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////////////////////////

  assign dq_out = cmd_i.quad ? shift_q[15:12] : {3'b000, shift_q[15]};

  assign pins_o = '{
    cs:  1'b0,  // Chip select is bit-bang only
    sck: sck,
    dq:  dq_out
  };

  assign mask_o = cmd_i.quad ? {4{cmd_i.dir}} : 4'b0010; // 1 = lane is input
  assign rx_o   = shift_q;
  assign idle_o = (state_q == XFER_IDLE);

endmodule

`default_nettype wire

//--- spi/spi_pin_stage.sv
`default_nettype none

module spi_pin_stage (
  input  wire logic                    pclk,
  input  wire logic                    SCKclock,
  input  wire spi_pin_pkg::spi_pins_t  bitbang_i,
  input  wire spi_pin_pkg::spi_pins_t  engine_i,
  input  wire spi_pin_pkg::spi_lanes_t mask_i,
  input  wire spi_pin_pkg::spi_lanes_t dq_i,
  output spi_pin_pkg::spi_pins_t       pins_o,
  output spi_pin_pkg::spi_lanes_t      oe_o,
  output spi_pin_pkg::spi_lanes_t      lanes_o
);
  import spi_pin_pkg::*;

  spi_pins_t  pins_q;
  spi_lanes_t oe_q;
  spi_lanes_t dq_meta;
  spi_lanes_t dq_sync;

  always_ff @(posedge pclk or posedge SCKclock) begin
    if (SCKclock) begin
      pins_q  <= '0;
      oe_q    <= 4'b1101;        // Single mode, MISO is input
      dq_meta <= '0;
      dq_sync <= '0;
    end else begin
      pins_q  <= bitbang_i | engine_i;
      oe_q    <= ~mask_i;
      dq_meta <= dq_i;           // Pad input, first flop
      dq_sync <= dq_meta;
    end
  end

  assign pins_o  = pins_q;
  assign oe_o    = oe_q;
  assign lanes_o = dq_sync;

endmodule

`default_nettype wire

//--- hw/spi_port_top.sv
`default_nettype none

module spi_port_top (
  input  wire logic                    pclk,
  input  wire logic                    SCKclock,
  input  wire io_bus_pkg::io_req_t     req_i,
  output io_bus_pkg::io_data_t         rd_data_o,
  output logic                         rd_valid_o,
  output spi_pin_pkg::spi_pins_t       pins_o,
  output spi_pin_pkg::spi_lanes_t      oe_o,
  input  wire spi_pin_pkg::spi_lanes_t dq_i
);
  import io_bus_pkg::*;
  import spi_pin_pkg::*;

  spi_cmd_t   cmd;
  spi_pins_t  bitbang;
  spi_pins_t  engine_pins;
  spi_lanes_t mask;
  spi_lanes_t lanes;       // Synchronized dq_i
  io_data_t   rx;
  logic       idle;

  spi_regs u_regs (
    .pclk       (pclk),
    .SCKclock   (SCKclock),
    .req_i      (req_i),
    .rx_i       (rx),
    .idle_i     (idle),
    .lanes_i    (lanes),
    .cmd_o      (cmd),
    .bitbang_o  (bitbang),
    .rd_data_o  (rd_data_o),
    .rd_valid_o (rd_valid_o)
  );

  spi_shift_engine u_engine (
    .pclk     (pclk),
    .SCKclock (SCKclock),
    .cmd_i    (cmd),
    .lanes_i  (lanes),
    .pins_o   (engine_pins),
    .mask_o   (mask),
    .rx_o     (rx),
    .idle_o   (idle)
  );

  spi_pin_stage u_pins (
    .pclk      (pclk),
    .SCKclock  (SCKclock),
    .bitbang_i (bitbang),
    .engine_i  (engine_pins),
    .mask_i    (mask),
    .dq_i      (dq_i),
    .pins_o    (pins_o),
    .oe_o      (oe_o),
    .lanes_o   (lanes)
  );

endmodule

`default_nettype wire

//--- verif/spi_engine_chk.sv
`default_nettype none

module spi_engine_chk (
  input wire logic                    pclk,
  input wire logic                    SCKclock,
  input wire spi_pin_pkg::spi_cmd_t   cmd_i,
  input wire spi_pin_pkg::spi_pins_t  pins_i,
  input wire spi_pin_pkg::spi_lanes_t mask_i,
  input wire logic                    idle_i
);

  ////////////////////////////////////////////////////////////
  // Engine properties
  ////////////////////////////////////////////////////////////

  a_idle_after_reset: assert property (@(posedge pclk) $fell(SCKclock) |-> idle_i)
    else $error("engine not idle in the first cycle after reset");

  a_one_start: assert property (@(posedge pclk) disable iff (SCKclock)
    !(cmd_i.start8 && cmd_i.start16))
    else $error("start8 and start16 high together");

  a_single_mask: assert property (@(posedge pclk) disable iff (SCKclock)
    !cmd_i.quad |-> (mask_i == 4'b0010)) // Only MISO is an input
    else $error("lane mask wrong in single mode");

  a_idle_sck: assert property (@(posedge pclk) disable iff (SCKclock)
    idle_i |-> !pins_i.sck)
    else $error("sck toggles while the engine is idle");

endmodule

bind spi_shift_engine spi_engine_chk u_chk (
  .pclk     (pclk),
  .SCKclock (SCKclock),
  .cmd_i    (cmd_i),
  .pins_i   (pins_o),
  .mask_i   (mask_o),
  .idle_i   (idle_o)
);

`default_nettype wire

//--- verif/spi_port_tb.sv
`include "spi_settings.svh"

`default_nettype none

module spi_port_tb;
  import io_bus_pkg::*;
  import spi_pin_pkg::*;

  logic       pclk;
  logic       SCKclock;
  io_req_t    req;
  io_data_t   rd_data;
  logic       rd_valid;
  spi_pins_t  pins;
  spi_lanes_t oe;
  spi_lanes_t dq;
  integer     seed;
  logic       mon_en;
  logic       sck_prev = 1'b0;
  logic       mosi_q[$];

  spi_port_top dut (
    .pclk       (pclk),
    .SCKclock   (SCKclock),
    .req_i      (req),
    .rd_data_o  (rd_data),
    .rd_valid_o (rd_valid),
    .pins_o     (pins),
    .oe_o       (oe),
    .dq_i       (dq)
  );

  initial begin
    pclk = 1'b0;
    forever #5 pclk = ~pclk;
  end

  // MOSI at each rising edge of the registered sck
  always @(posedge pclk) begin
    #2;
    if (mon_en && pins.sck && !sck_prev)
      mosi_q.push_back(pins.dq[0]);
    sck_prev = pins.sck;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge pclk);
    #1;
  endtask

  task automatic draw(output logic [31:0] v);
    v = $random(seed);
  endtask

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input io_addr_t address, input io_data_t data);
    req = '{wr: 1'b1, rd: 1'b0, addr: address, wdata: data};
    tick();
    req = '0;
  endtask

  task automatic bus_read(input io_addr_t address, output io_data_t data);
    req = '{wr: 1'b0, rd: 1'b1, addr: address, wdata: 16'h0000};
    check_value("rd_valid_o", {15'd0, rd_valid}, 16'h0000);
    tick();
    req = '0;
    check_value("rd_valid_o", {15'd0, rd_valid}, 16'h0001);
    data = rd_data;
    tick();
    check_value("rd_valid_o", {15'd0, rd_valid}, 16'h0000);
  endtask

  task automatic wait_idle();
    io_data_t v;
    integer   n;
    v = '0;
    n = 0;
    while (v[0] !== 1'b1) begin
      if (n == 200) begin
        $display("Timeout: the SPI engine never returned to idle");
        $display("tests failed");
        $fatal(1);
      end
      bus_read(`SPI_REG_IDLE, v);
      n = n + 1;
    end
  endtask

  // Byte-swapped tx, shifted left with the input lanes filled in
  function automatic io_data_t expected_rx(input io_data_t tx, input logic quad,
                                           input logic wide, input spi_lanes_t lanes);
    io_data_t r;
    integer   bits;
    r = {tx[7:0], tx[15:8]};
    bits = wide ? 16 : 8;
    if (quad) begin
      for (int i = 0; i < bits / 4; i++)
        r = {r[11:0], lanes};
    end else begin
      for (int i = 0; i < bits; i++)
        r = {r[14:0], lanes[1]};
    end
    return r;
  endfunction

  task automatic run_transfer(input logic quad, input logic wide, input logic restart);
    logic [31:0] r;
    io_data_t    tx;
    io_data_t    rx;
    io_data_t    busy;
    integer      bits;
    logic        exp_bit;
    draw(r);
    tx = r[15:0];
    bits = wide ? 16 : 8;
    dq = r[19:16];       // Held through the whole transfer
    repeat (3) tick();
    if (restart) begin
      bus_write(`SPI_REG_START16, ~tx);
      repeat (2 + r[23:21]) tick();
    end
    mosi_q.delete();
    mon_en = !quad && !restart;
    bus_write(wide ? `SPI_REG_START16 : `SPI_REG_START8, tx);
    if (quad)
      check_value("oe_o", {12'd0, oe}, 16'h0000);
    bus_read(`SPI_REG_IDLE, busy);
    check_value("idle", busy, 16'h0000);
    wait_idle();
    mon_en = 1'b0;
    bus_read(r[24] ? `SPI_REG_START16 : `SPI_REG_START8, rx);
    check_value("rx", rx, expected_rx(tx, quad, wide, dq));
    if (!quad && !restart) begin
      check_value("sck edges", 16'(mosi_q.size()), 16'(bits));
      for (int i = 0; i < bits; i++) begin
        exp_bit = (i < 8) ? tx[7 - i] : tx[23 - i]; // Low byte first, MSB first
        check_value("pins_o.dq[0]", {15'd0, mosi_q[i]}, {15'd0, exp_bit});
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    io_data_t    v;
    logic [5:0]  bb;
    seed = 53;
    mon_en = 1'b0;
    req = '0;
    dq = '0;
    bb = '0;
    SCKclock = 1'b1;
    repeat (4) @(posedge pclk);
    #1;
    SCKclock = 1'b0;
    tick();

    check_value("pins_o", {10'd0, pins}, 16'h0000);
    check_value("oe_o", {12'd0, oe}, 16'h000d);
    check_value("rd_valid_o", {15'd0, rd_valid}, 16'h0000);
    bus_read(`SPI_REG_IDLE, v);
    check_value("idle", v, 16'h0001);

    // Bit-bang pins and lane read-back
    repeat (8) begin
      draw(r);
      dq = r[3:0];
      bus_write(`SPI_REG_PINS, {10'd0, r[9:4]});
      check_value("pins_o", {10'd0, pins}, {10'd0, bb});
      tick();
      check_value("pins_o", {10'd0, pins}, {10'd0, r[9:4]});
      bb = r[9:4];
      repeat (2) tick();
      bus_read(`SPI_REG_PINS, v);
      check_value("lanes", v, {12'd0, r[3:0]});
    end
    bus_write(`SPI_REG_PINS, 16'h0000);

    for (int i = 0; i < 8; i++)
      run_transfer(1'b0, i[0], 1'b0);

    // Quad mode, all lanes inputs
    bus_write(`SPI_REG_QUAD, 16'h0001);
    bus_write(`SPI_REG_DIR, 16'h0001);
    tick();
    check_value("oe_o", {12'd0, oe}, 16'h0000);
    for (int i = 0; i < 6; i++)
      run_transfer(1'b1, i[0], 1'b0);
    bus_write(`SPI_REG_DIR, 16'h0000);
    tick();
    check_value("oe_o", {12'd0, oe}, 16'h000f);
    bus_write(`SPI_REG_QUAD, 16'h0000);
    tick();
    check_value("oe_o", {12'd0, oe}, 16'h000d);

    for (int i = 0; i < 4; i++)
      run_transfer(1'b0, i[0], 1'b1);

    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+common
common/io_bus_pkg.sv
common/spi_pin_pkg.sv
hw/spi_regs.sv
spi/spi_shift_engine.sv
spi/spi_pin_stage.sv
hw/spi_port_top.sv
verif/spi_engine_chk.sv
verif/spi_port_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the SPI port simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module spi_port_tb -f list.f -o spi_port_sim

status=0
./obj_dir/spi_port_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "tests failed" sim.log || [ "$status" -ne 0 ]; then
  echo "FAIL"
  exit 1
fi

echo "PASS"
exit 0
